//--- soc_pkg.sv
package soc_pkg;

    // ====================
    // bus widths.
    // ====================
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;                       // one bit per byte lane.

    // ====================
    // memory map.
    // ====================
    localparam int RAM_DEPTH = 256;                  // words.
    localparam int RAM_AW    = $clog2(RAM_DEPTH);

    localparam logic [ADDR_W-1:0] RAM_LAST_ADDR  = ADDR_W'(RAM_DEPTH * SEL_W - 1);
    localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 16'h1000;  // write only, byte in [7:0].
    localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 16'h1004;  // read only.
    localparam logic [ADDR_W-1:0] GPIO_OUT_ADDR  = 16'h2000;
    localparam logic [ADDR_W-1:0] GPIO_IN_ADDR   = 16'h2004;

    // ====================
    // uart sizing.
    // ====================
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = FIFO_AW + 1;         // count reaches FIFO_DEPTH.

    // clocks per bit, small so frames stay short in simulation.
    localparam int BAUD_DIV = 8;
    localparam int BAUD_CW  = $clog2(BAUD_DIV);

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_UART,
        SEL_GPIO,
        SEL_NONE
    } slave_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } uart_state_e;

endpackage

//--- dbus_decoder.sv
module dbus_decoder import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    // master side.
    input  logic              m_cyc_i,
    input  logic              m_stb_i,
    input  logic [ADDR_W-1:0] m_adr_i,
    output logic [DATA_W-1:0] m_dat_o,
    output logic              m_ack_o,
    output logic              m_err_o,
    // slave side.
    output logic              ram_stb_o,
    input  logic              ram_ack_i,
    input  logic [DATA_W-1:0] ram_dat_i,
    output logic              uart_stb_o,
    input  logic              uart_ack_i,
    input  logic [DATA_W-1:0] uart_dat_i,
    output logic              gpio_stb_o,
    input  logic              gpio_ack_i,
    input  logic [DATA_W-1:0] gpio_dat_i
);

    slave_sel_e sel;
    logic       req;
    logic       err_q;

    assign req = m_cyc_i & m_stb_i;

    // ====================
    // address decode
    // ====================
    always_comb begin
        if (m_adr_i <= RAM_LAST_ADDR) begin
            sel = SEL_RAM;
        end else if (m_adr_i == UART_DATA_ADDR || m_adr_i == UART_STAT_ADDR) begin
            sel = SEL_UART;
        end else if (m_adr_i == GPIO_OUT_ADDR || m_adr_i == GPIO_IN_ADDR) begin
            sel = SEL_GPIO;
        end else begin
            sel = SEL_NONE;                          // hole in the map.
        end
    end

    assign ram_stb_o  = req & (sel == SEL_RAM);
    assign uart_stb_o = req & (sel == SEL_UART);
    assign gpio_stb_o = req & (sel == SEL_GPIO);

    // address is held until ack, so the mux can follow sel directly.
    always_comb begin
        case (sel)
            SEL_RAM:  m_dat_o = ram_dat_i;
            SEL_UART: m_dat_o = uart_dat_i;
            SEL_GPIO: m_dat_o = gpio_dat_i;
            default:  m_dat_o = '0;
        endcase
    end

    always_comb begin
        case (sel)
            SEL_RAM:  m_ack_o = ram_ack_i;
            SEL_UART: m_ack_o = uart_ack_i;
            SEL_GPIO: m_ack_o = gpio_ack_i;
            default:  m_ack_o = 1'b0;
        endcase
    end

    // one cycle err for unmapped addresses.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & (sel == SEL_NONE) & ~err_q;
        end
    end

    assign m_err_o = err_q;

    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (reset_i) !(m_ack_o && m_err_o)
    );

    a_ack_needs_cyc: assert property (
        @(posedge clk) disable iff (reset_i) $rose(m_ack_o) |-> m_cyc_i
    );

endmodule

//--- data_ram.sv
module data_ram import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];
    logic [RAM_AW-1:0] word_idx;
    logic              access;

    assign word_idx = adr_i[RAM_AW+1:2];             // byte address to word.
    assign access   = stb_i & ~ack_o;                // first edge of the cycle only.

    always_ff @(posedge clk) begin
        if (access && we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        if (access) begin
            dat_o <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    // ack rises while stb is held and lasts one cycle.
    a_ack_single: assert property (
        @(posedge clk) disable iff (reset_i) $rose(ack_o) |-> stb_i ##1 !ack_o
    );

endmodule

//--- uart_tx_fifo.sv
module uart_tx_fifo import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    // serializer side.
    input  logic              fifo_pop_i,
    input  logic              tx_busy_i,
    output logic              fifo_valid_o,
    output logic [7:0]        fifo_data_o
);

    logic [7:0]         fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               empty;
    logic               full;
    logic               is_data;
    logic               stall;
    logic               push;
    logic [DATA_W-1:0]  status;

    assign empty   = (count == '0);
    assign full    = (count == FIFO_CW'(FIFO_DEPTH));
    assign is_data = (adr_i == UART_DATA_ADDR);

    // data write waits here while the FIFO is full.
    assign stall = we_i & is_data & full;
    assign push  = stb_i & ~ack_o & we_i & is_data & ~full;

    assign status = {{(DATA_W-8){1'b0}}, count, 1'b0, tx_busy_i, full, empty};

    // ====================
    // bus registers
    // ====================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o & ~stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i && !ack_o) begin
            dat_o <= is_data ? '0 : status;          // data register reads as zero.
        end
    end

    // ====================
    // circular buffer
    // ====================
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= dat_i[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;       // wraps at FIFO_DEPTH.
            if (fifo_pop_i) rd_ptr <= rd_ptr + 1'b1;
            case ({push, fifo_pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign fifo_valid_o = ~empty;
    assign fifo_data_o  = fifo_mem[rd_ptr];

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset_i) full && !fifo_pop_i |=> full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset_i) fifo_pop_i |-> !empty
    );

endmodule

//--- uart_tx.sv
module uart_tx import soc_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       fifo_valid_i,
    input  logic [7:0] fifo_data_i,
    output logic       fifo_pop_o,
    output logic       tx_busy_o,
    output logic       txd_o
);

    uart_state_e        state;
    logic [BAUD_CW-1:0] baud_cnt;
    logic [2:0]         bit_idx;
    logic [7:0]         shift_q;
    logic               bit_end;

    assign bit_end    = (baud_cnt == BAUD_CW'(BAUD_DIV - 1));
    assign fifo_pop_o = (state == ST_IDLE) & fifo_valid_i;
    assign tx_busy_o  = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd_o    <= 1'b1;                        // line idles high.
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    baud_cnt <= '0;
                    if (fifo_valid_i) begin
                        state <= ST_START;
                        txd_o <= 1'b0;               // start bit on the pop edge.
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        state   <= ST_DATA;
                        bit_idx <= '0;
                        txd_o   <= shift_q[0];       // lsb first.
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= ST_STOP;
                            txd_o <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd_o   <= shift_q[0];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // shift register holds the frame payload.
    always_ff @(posedge clk) begin
        if (fifo_pop_o) begin
            shift_q <= fifo_data_i;
        end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_idle_high: assert property (
        @(posedge clk) disable iff (reset_i) (state == ST_IDLE) |-> txd_o
    );

endmodule

//--- gpio_regs.sv
module gpio_regs import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    input  logic [DATA_W-1:0] gpio_in_i,
    output logic [DATA_W-1:0] gpio_out_o
);

    logic [DATA_W-1:0] in_meta;
    logic [DATA_W-1:0] in_sync;
    logic              access;
    logic              is_in;

    assign access = stb_i & ~ack_o;
    assign is_in  = (adr_i == GPIO_IN_ADDR);        // writes here are dropped.

    // two flop synchronizer.
    always_ff @(posedge clk) begin
        in_meta <= gpio_in_i;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            gpio_out_o <= '0;
            ack_o      <= 1'b0;
        end else begin
            ack_o <= access;
            if (access && we_i && !is_in) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel_i[b]) gpio_out_o[8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= is_in ? in_sync : gpio_out_o;
        end
    end

endmodule

//--- soc_dbus_top.sv
module soc_dbus_top import soc_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [SEL_W-1:0]  wb_sel_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack_o,
    output logic              wb_err_o,
    output logic              txd_o,
    input  logic [DATA_W-1:0] gpio_in_i,
    output logic [DATA_W-1:0] gpio_out_o
);

    logic              ram_stb;
    logic              ram_ack;
    logic [DATA_W-1:0] ram_dat;
    logic              uart_stb;
    logic              uart_ack;
    logic [DATA_W-1:0] uart_dat;
    logic              gpio_stb;
    logic              gpio_ack;
    logic [DATA_W-1:0] gpio_dat;

    // fifo to serializer.
    logic              fifo_valid;
    logic [7:0]        fifo_data;
    logic              fifo_pop;
    logic              tx_busy;

    dbus_decoder u_decoder (
        .clk        (clk),
        .reset_i    (reset_i),
        .m_cyc_i    (wb_cyc_i),
        .m_stb_i    (wb_stb_i),
        .m_adr_i    (wb_adr_i),
        .m_dat_o    (wb_dat_o),
        .m_ack_o    (wb_ack_o),
        .m_err_o    (wb_err_o),
        .ram_stb_o  (ram_stb),
        .ram_ack_i  (ram_ack),
        .ram_dat_i  (ram_dat),
        .uart_stb_o (uart_stb),
        .uart_ack_i (uart_ack),
        .uart_dat_i (uart_dat),
        .gpio_stb_o (gpio_stb),
        .gpio_ack_i (gpio_ack),
        .gpio_dat_i (gpio_dat)
    );

    data_ram u_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .stb_i   (ram_stb),
        .we_i    (wb_we_i),
        .adr_i   (wb_adr_i),
        .sel_i   (wb_sel_i),
        .dat_i   (wb_dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    uart_tx_fifo u_uart_fifo (
        .clk          (clk),
        .reset_i      (reset_i),
        .stb_i        (uart_stb),
        .we_i         (wb_we_i),
        .adr_i        (wb_adr_i),
        .dat_i        (wb_dat_i),
        .dat_o        (uart_dat),
        .ack_o        (uart_ack),
        .fifo_pop_i   (fifo_pop),
        .tx_busy_i    (tx_busy),
        .fifo_valid_o (fifo_valid),
        .fifo_data_o  (fifo_data)
    );

    uart_tx u_uart_tx (
        .clk          (clk),
        .reset_i      (reset_i),
        .fifo_valid_i (fifo_valid),
        .fifo_data_i  (fifo_data),
        .fifo_pop_o   (fifo_pop),
        .tx_busy_o    (tx_busy),
        .txd_o        (txd_o)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .reset_i    (reset_i),
        .stb_i      (gpio_stb),
        .we_i       (wb_we_i),
        .adr_i      (wb_adr_i),
        .sel_i      (wb_sel_i),
        .dat_i      (wb_dat_i),
        .dat_o      (gpio_dat),
        .ack_o      (gpio_ack),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

endmodule

//--- tb_soc_dbus_top.sv
module tb_soc_dbus_top import soc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int WATCHDOG_NS = 2 * (20 * 10 * BAUD_DIV * CLK_PERIOD + 2000 * CLK_PERIOD);
    localparam logic [31:0] SEED = 32'h13f1_7331;

    logic              clk;
    logic              reset_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [ADDR_W-1:0] wb_adr_i;
    logic [SEL_W-1:0]  wb_sel_i;
    logic [DATA_W-1:0] wb_dat_i;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack_o;
    logic              wb_err_o;
    logic              txd_o;
    logic [DATA_W-1:0] gpio_in_i;
    logic [DATA_W-1:0] gpio_out_o;

    logic              resp_ack;                     // response of the last bus cycle.
    logic              resp_err;
    int                resp_lat;
    logic [7:0]        exp_q [$];                    // bytes written, not yet seen on txd.
    int                errors = 0;
    int                pass_cnt = 0;
    int                fail_cnt = 0;

    soc_dbus_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // bus checks
    // ====================
    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (reset_i) !(wb_ack_o && wb_err_o)
    ) else begin
        $display("ack and err were high in the same cycle");
        errors++;
    end

    a_quiet_no_cyc: assert property (
        @(posedge clk) disable iff (reset_i) !wb_cyc_i |-> !wb_ack_o && !wb_err_o
    ) else begin
        $display("a response was seen with no bus cycle open");
        errors++;
    end

    a_resp_single: assert property (
        @(posedge clk) disable iff (reset_i) (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o)
    ) else begin
        $display("a bus response lasted more than one cycle");
        errors++;
    end

    a_txd_idle: assert property (
        @(posedge clk) disable iff (reset_i) (dut.u_uart_tx.state == ST_IDLE) |-> txd_o
    ) else begin
        $display("txd_o was low while the serializer was idle");
        errors++;
    end

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s expected 0x%h got 0x%h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw, logic [3:0] s);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    // status layout: count in [7:4], busy, full, empty in [2:0].
    function automatic logic [31:0] status_word(int cnt, logic busy, logic full, logic empty);
        logic [31:0] w;
        w      = '0;
        w[0]   = empty;
        w[1]   = full;
        w[2]   = busy;
        w[7:4] = 4'(cnt);
        return w;
    endfunction

    task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        resp_lat = 0;
        @(negedge clk);
        while (!(wb_ack_o || wb_err_o)) begin
            resp_lat++;                              // clocks after stb was first sampled.
            @(negedge clk);
        end
        rdat     = wb_dat_o;
        resp_ack = wb_ack_o;
        resp_err = wb_err_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, '0, 4'hF, rdat);
    endtask

    task automatic check_single_ack();
        expect_eq("wb_ack_o", 1, resp_ack);
        expect_eq("wb_err_o", 0, resp_err);
        expect_eq("ack latency", 1, resp_lat);
    endtask

    task automatic wait_uart_drain(input int max_clks);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || dut.u_uart_tx.state != ST_IDLE) && n < max_clks) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d written bytes never appeared on txd_o", exp_q.size());
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, errors - mark);
        end
    endtask

    // ====================
    // uart line monitor
    // ====================
    initial begin : uart_monitor
        logic [7:0] rx;
        wait (reset_i === 1'b0);
        forever begin
            @(negedge txd_o);
            repeat (BAUD_DIV / 2) @(negedge clk);    // middle of the start bit.
            assert (txd_o === 1'b0) else begin
                $display("start bit on txd_o did not hold low");
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk);
                rx[i] = txd_o;                       // lsb first.
            end
            repeat (BAUD_DIV) @(negedge clk);
            assert (txd_o === 1'b1) else begin
                $display("stop bit missing on txd_o");
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("byte 0x%h seen on txd_o with none written", rx);
                errors++;
            end else begin
                expect_eq("txd_o byte", 32'(exp_q.pop_front()), 32'(rx));
            end
        end
    end

    // ====================
    // tests
    // ====================
    task automatic reset_defaults();
        int          mark;
        logic [31:0] rd;
        mark = errors;
        @(negedge clk);
        expect_eq("txd_o", 1, txd_o);
        expect_eq("gpio_out_o", 0, gpio_out_o);
        repeat (4) begin
            @(negedge clk);
            expect_eq("wb_ack_o", 0, wb_ack_o);
            expect_eq("wb_err_o", 0, wb_err_o);
        end
        wb_read(UART_STAT_ADDR, rd);
        check_single_ack();
        expect_eq("wb_dat_o", status_word(0, 1'b0, 1'b0, 1'b1), rd);
        finish_test("reset", mark);
    endtask

    task automatic ram_random_access();
        int          mark;
        int          w;
        int          words [8];
        logic [31:0] d;
        logic [31:0] rd;
        logic [3:0]  s;
        logic [31:0] model [int];
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            words[i] = $urandom_range(RAM_DEPTH - 1);
            d = $urandom;
            wb_write(16'(words[i] * 4), d, 4'hF);    // every byte gets a known value.
            check_single_ack();
            model[words[i]] = d;
        end
        for (int i = 0; i < 24; i++) begin
            w = words[$urandom_range(7)];
            d = $urandom;
            s = 4'($urandom_range(15));
            wb_write(16'(w * 4), d, s);
            check_single_ack();
            model[w] = merge_bytes(model[w], d, s);
        end
        foreach (model[k]) begin
            wb_read(16'(k * 4), rd);
            check_single_ack();
            expect_eq("wb_dat_o", model[k], rd);
        end
        finish_test("ram", mark);
    endtask

    task automatic unmapped_errors();
        int          mark;
        logic [31:0] rd;
        mark = errors;
        wb_read(16'h3000, rd);
        expect_eq("wb_err_o", 1, resp_err);
        expect_eq("wb_ack_o", 0, resp_ack);
        expect_eq("err latency", 1, resp_lat);
        wb_write(16'h1008, $urandom, 4'hF);
        expect_eq("wb_err_o", 1, resp_err);
        expect_eq("wb_ack_o", 0, resp_ack);
        wb_read(16'h0400, rd);                       // first byte past the ram.
        expect_eq("wb_err_o", 1, resp_err);
        expect_eq("wb_ack_o", 0, resp_ack);
        finish_test("unmapped", mark);
    endtask

    task automatic uart_single_frames();
        int         mark;
        logic [7:0] b;
        mark = errors;
        for (int i = 0; i < 4; i++) begin
            b = 8'($urandom_range(255));
            exp_q.push_back(b);
            wb_write(UART_DATA_ADDR, {24'h0, b}, 4'h1);
            check_single_ack();
            wait_uart_drain(12 * BAUD_DIV);
        end
        finish_test("uart frames", mark);
    endtask

    task automatic fifo_backpressure();
        int          mark;
        int          max_lat;
        logic [7:0]  b;
        logic [31:0] rd;
        mark = errors;
        max_lat = 0;
        for (int i = 0; i < 12; i++) begin
            b = 8'($urandom_range(255));
            exp_q.push_back(b);
            wb_write(UART_DATA_ADDR, {24'h0, b}, 4'h1);
            expect_eq("wb_ack_o", 1, resp_ack);
            if (resp_lat > max_lat) max_lat = resp_lat;
            if (i == 8) begin
                // one byte on the wire, eight waiting.
                wb_read(UART_STAT_ADDR, rd);
                expect_eq("wb_dat_o", status_word(FIFO_DEPTH, 1'b1, 1'b1, 1'b0), rd);
            end
        end
        assert (max_lat > 1) else begin
            $display("no data write ack was held back by a full FIFO");
            errors++;
        end
        wait_uart_drain(13 * 11 * BAUD_DIV);
        finish_test("back-pressure", mark);
    endtask

    task automatic gpio_in_out();
        int          mark;
        logic [31:0] d;
        logic [31:0] rd;
        logic [31:0] gmodel;
        logic [3:0]  s;
        mark = errors;
        gmodel = '0;
        repeat (4) begin
            d = $urandom;
            s = 4'($urandom_range(1, 15));
            wb_write(GPIO_OUT_ADDR, d, s);
            check_single_ack();
            gmodel = merge_bytes(gmodel, d, s);
            @(negedge clk);
            expect_eq("gpio_out_o", gmodel, gpio_out_o);
            wb_read(GPIO_OUT_ADDR, rd);
            expect_eq("wb_dat_o", gmodel, rd);
        end
        wb_write(GPIO_IN_ADDR, ~gmodel, 4'hF);
        check_single_ack();
        @(negedge clk);
        expect_eq("gpio_out_o", gmodel, gpio_out_o);
        d = $urandom;
        @(posedge clk);
        gpio_in_i <= d;
        repeat (3) @(posedge clk);                   // through the synchronizer.
        wb_read(GPIO_IN_ADDR, rd);
        check_single_ack();
        expect_eq("wb_dat_o", d, rd);
        finish_test("gpio", mark);
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        reset_i   = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_sel_i  = '0;
        wb_dat_i  = '0;
        gpio_in_i = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        reset_defaults();
        ram_random_access();
        unmapped_errors();
        uart_single_frames();
        fifo_backpressure();
        gpio_in_out();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (errors == 0 && fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- soc_dbus_top.f
soc_pkg.sv
dbus_decoder.sv
data_ram.sv
uart_tx_fifo.sv
uart_tx.sv
gpio_regs.sv
soc_dbus_top.sv
tb_soc_dbus_top.sv
